/* rtl/mii_loop_pkg.sv */
// Fixed sizes for the MII loopback core; the buffer depth and gap length are set here only.
`default_nettype none

package mii_loop_pkg;

    localparam int BUF_DEPTH  = 256; // Bytes of frame storage.
    localparam int IFG_CYCLES = 24;  // Twelve byte times at one nibble per clk.

    typedef logic [3:0]  nibble_t;
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] count_t;
    typedef logic [$clog2(BUF_DEPTH)-1:0] buf_addr_t;
    typedef logic [$clog2(BUF_DEPTH):0]   buf_level_t; // One bit wider so a full buffer fits.
    typedef logic [$clog2(IFG_CYCLES)-1:0] gap_cnt_t;

    // One byte on the receive path; err is only meaningful on the beat with last set.
    typedef struct packed {
        logic  valid;
        byte_t data;
        logic  last;
        logic  err;
    } beat_t;

    typedef struct packed {
        count_t rx_frames;
        count_t rx_bytes;
        count_t rx_bad_frames;
        count_t tx_frames;
    } stats_t;

    typedef enum logic [1:0] {
        RX_IDLE, // No frame in progress.
        RX_LOW,  // Expecting the low nibble of a byte.
        RX_HIGH  // Expecting the high nibble of a byte.
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SEND_LOW,
        TX_SEND_HIGH,
        TX_GAP
    } tx_state_t;

endpackage

`default_nettype wire

/* rtl/mii_rx_framer.sv */
// PHY receive is taken to run on clk, one nibble per cycle; an odd trailing nibble is dropped.
`timescale 1ns/1ps
`default_nettype none

module mii_rx_framer (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire mii_loop_pkg::nibble_t phy_rxd,
    input  wire logic                  phy_rx_dv,
    input  wire logic                  phy_rx_er,
    output mii_loop_pkg::beat_t        rx_beat
);

mii_loop_pkg::rx_state_t state;
mii_loop_pkg::nibble_t   low_nib;    // Low nibble waiting for its partner.
mii_loop_pkg::byte_t     hold_data;  // Last complete byte, not yet emitted.
logic                    hold_valid;
logic                    err_q;      // Sticky rx_er flag for the current frame.
logic                    err_now;

assign err_now = err_q | phy_rx_er;

always_ff @(posedge clk) begin
    if (rst) begin
        state      <= mii_loop_pkg::RX_IDLE;
        hold_valid <= 1'b0;
        err_q      <= 1'b0;
        rx_beat    <= '0;
    end else begin
        rx_beat.valid <= 1'b0; // Beats are single-cycle strobes.
        case (state)
            mii_loop_pkg::RX_IDLE: begin
                if (phy_rx_dv) begin
                    low_nib <= phy_rxd;
                    err_q   <= phy_rx_er; // A new frame starts with a clean error flag.
                    state   <= mii_loop_pkg::RX_HIGH;
                end
            end
            mii_loop_pkg::RX_HIGH: begin
                if (phy_rx_dv) begin
                    if (hold_valid) begin
                        rx_beat <= '{valid: 1'b1, data: hold_data, last: 1'b0, err: err_now};
                    end
                    hold_data  <= {phy_rxd, low_nib};
                    hold_valid <= 1'b1;
                    err_q      <= err_now;
                    state      <= mii_loop_pkg::RX_LOW;
                end else begin
                    // The lone low nibble is discarded here.
                    if (hold_valid) begin
                        rx_beat <= '{valid: 1'b1, data: hold_data, last: 1'b1, err: err_q};
                    end
                    hold_valid <= 1'b0;
                    state      <= mii_loop_pkg::RX_IDLE;
                end
            end
            mii_loop_pkg::RX_LOW: begin
                if (phy_rx_dv) begin
                    low_nib <= phy_rxd;
                    err_q   <= err_now;
                    state   <= mii_loop_pkg::RX_HIGH;
                end else begin
                    rx_beat    <= '{valid: 1'b1, data: hold_data, last: 1'b1, err: err_q};
                    hold_valid <= 1'b0;
                    state      <= mii_loop_pkg::RX_IDLE;
                end
            end
            default: state <= mii_loop_pkg::RX_IDLE;
        endcase
    end
end

endmodule

`default_nettype wire

/* rtl/frame_buffer.sv */
// No overflow protection: senders must keep the stored bytes under BUF_DEPTH; err is not stored.
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire mii_loop_pkg::beat_t rx_beat,
    input  wire logic                pop,
    output wire mii_loop_pkg::beat_t head,
    output wire logic                frame_ready
);

mii_loop_pkg::byte_t      data_mem [mii_loop_pkg::BUF_DEPTH];
logic                     last_mem [mii_loop_pkg::BUF_DEPTH];
mii_loop_pkg::buf_addr_t  wr_ptr;
mii_loop_pkg::buf_addr_t  rd_ptr;
mii_loop_pkg::buf_level_t level;   // Bytes currently stored.
mii_loop_pkg::buf_level_t frames;  // Complete frames currently stored.
logic                     wr_en;
logic                     rd_en;
logic                     wr_frame;
logic                     rd_frame;

assign wr_en    = rx_beat.valid;
assign rd_en    = pop && (level != '0);
assign wr_frame = wr_en && rx_beat.last;
assign rd_frame = rd_en && last_mem[rd_ptr];

// The head is read straight from the array, so a byte is visible the cycle after its write.
assign head = '{
    valid: (level != '0),
    data:  data_mem[rd_ptr],
    last:  last_mem[rd_ptr],
    err:   1'b0
};

assign frame_ready = (frames != '0); // Transmit may only start on a fully received frame.

always_ff @(posedge clk) begin
    if (wr_en) begin
        data_mem[wr_ptr] <= rx_beat.data;
        last_mem[wr_ptr] <= rx_beat.last;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        level  <= '0;
        frames <= '0;
    end else begin
        if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1; // Pointers wrap at BUF_DEPTH.
        end
        if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        case ({wr_en, rd_en})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
        endcase
        case ({wr_frame, rd_frame})
            2'b10:   frames <= frames + 1'b1;
            2'b01:   frames <= frames - 1'b1;
            default: frames <= frames;
        endcase
    end
end

endmodule

`default_nettype wire

/* rtl/frame_stats.sv */
// All counters are free running and wrap silently at 2**32.
`timescale 1ns/1ps
`default_nettype none

module frame_stats (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire mii_loop_pkg::beat_t rx_beat,
    input  wire logic                tx_done,
    output mii_loop_pkg::stats_t     stats
);

logic rx_last;

assign rx_last = rx_beat.valid && rx_beat.last;

always_ff @(posedge clk) begin
    if (rst) begin
        stats <= '0;
    end else begin
        if (rx_beat.valid) begin
            stats.rx_bytes <= stats.rx_bytes + 1'b1;
        end
        if (rx_last) begin
            stats.rx_frames <= stats.rx_frames + 1'b1;
        end
        if (rx_last && rx_beat.err) begin
            stats.rx_bad_frames <= stats.rx_bad_frames + 1'b1; // Error flag is sticky over the frame.
        end
        if (tx_done) begin
            stats.tx_frames <= stats.tx_frames + 1'b1;
        end
    end
end

endmodule

`default_nettype wire

/* rtl/mii_tx_serializer.sv */
// PHY transmit is taken to run on clk; frames go out raw, with no preamble, padding or FCS.
`timescale 1ns/1ps
`default_nettype none

module mii_tx_serializer (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire mii_loop_pkg::beat_t   head,
    input  wire logic                  frame_ready,
    output wire logic                  pop,
    output wire logic                  tx_done,
    output wire mii_loop_pkg::nibble_t phy_txd,
    output wire logic                  phy_tx_en
);

mii_loop_pkg::tx_state_t state;
mii_loop_pkg::gap_cnt_t  gap_cnt; // Remaining idle cycles after the current one.

assign phy_tx_en = (state == mii_loop_pkg::TX_SEND_LOW) || (state == mii_loop_pkg::TX_SEND_HIGH);
assign phy_txd   = !phy_tx_en ? '0 :
                   (state == mii_loop_pkg::TX_SEND_HIGH) ? head.data[7:4] : head.data[3:0];

assign pop     = (state == mii_loop_pkg::TX_SEND_HIGH); // Byte leaves after its high nibble.
assign tx_done = pop && head.last;

always_ff @(posedge clk) begin
    if (rst) begin
        state   <= mii_loop_pkg::TX_IDLE;
        gap_cnt <= '0;
    end else begin
        case (state)
            mii_loop_pkg::TX_IDLE: begin
                if (frame_ready) begin
                    state <= mii_loop_pkg::TX_SEND_LOW;
                end
            end
            mii_loop_pkg::TX_SEND_LOW: begin
                state <= mii_loop_pkg::TX_SEND_HIGH;
            end
            mii_loop_pkg::TX_SEND_HIGH: begin
                if (head.last) begin
                    state   <= mii_loop_pkg::TX_GAP;
                    gap_cnt <= mii_loop_pkg::gap_cnt_t'(mii_loop_pkg::IFG_CYCLES - 1);
                end else begin
                    state <= mii_loop_pkg::TX_SEND_LOW; // Frame is complete in the buffer, so no stall.
                end
            end
            mii_loop_pkg::TX_GAP: begin
                if (gap_cnt == '0) begin
                    // A waiting frame follows straight on, keeping the gap at exactly IFG_CYCLES.
                    state <= frame_ready ? mii_loop_pkg::TX_SEND_LOW : mii_loop_pkg::TX_IDLE;
                end else begin
                    gap_cnt <= gap_cnt - 1'b1;
                end
            end
            default: state <= mii_loop_pkg::TX_IDLE;
        endcase
    end
end

endmodule

`default_nettype wire

/* rtl/mii_loop_core.sv */
// MII loopback core; both PHY clocks must be the same as clk, and the buffer must never overflow.
`timescale 1ns/1ps
`default_nettype none

module mii_loop_core (
    // Single clock domain, synchronous active-high reset.
    input  wire logic                  clk,
    input  wire logic                  rst,

    // GPIO.
    input  wire logic [3:0]            btn,
    input  wire logic [3:0]            sw,
    output wire logic [7:0]            led,

    // Ethernet, 100BASE-T MII.
    input  wire mii_loop_pkg::nibble_t phy_rxd,
    input  wire logic                  phy_rx_dv,
    input  wire logic                  phy_rx_er,
    output wire mii_loop_pkg::nibble_t phy_txd,
    output wire logic                  phy_tx_en,
    output wire logic                  phy_reset_n,

    // Traffic counters.
    output mii_loop_pkg::stats_t       stats
);

mii_loop_pkg::beat_t rx_beat;
mii_loop_pkg::beat_t head;
logic                frame_ready;
logic                pop;
logic                tx_done;

assign led         = {sw, btn}; // Switches on the upper four LEDs.
assign phy_reset_n = !rst;      // PHY is held in reset together with the core.

mii_rx_framer rx_framer_inst (
    .clk       (clk),
    .rst       (rst),
    .phy_rxd   (phy_rxd),
    .phy_rx_dv (phy_rx_dv),
    .phy_rx_er (phy_rx_er),
    .rx_beat   (rx_beat)
);

frame_buffer frame_buffer_inst (
    .clk         (clk),
    .rst         (rst),
    .rx_beat     (rx_beat),
    .pop         (pop),
    .head        (head),
    .frame_ready (frame_ready)
);

frame_stats frame_stats_inst (
    .clk     (clk),
    .rst     (rst),
    .rx_beat (rx_beat),
    .tx_done (tx_done),
    .stats   (stats)
);

mii_tx_serializer tx_serializer_inst (
    .clk         (clk),
    .rst         (rst),
    .head        (head),
    .frame_ready (frame_ready),
    .pop         (pop),
    .tx_done     (tx_done),
    .phy_txd     (phy_txd),
    .phy_tx_en   (phy_tx_en)
);

endmodule

`default_nettype wire

/* bench/mii_loop_core_chk.sv */
// Bound into mii_loop_core; the shadow fill level assumes the buffer is empty when rst is released.
`timescale 1ns/1ps
`default_nettype none

module mii_loop_core_chk (
    input wire logic                clk,
    input wire logic                rst,
    input wire mii_loop_pkg::beat_t rx_beat,
    input wire mii_loop_pkg::beat_t head,
    input wire logic                pop,
    input wire logic                phy_tx_en
);

mii_loop_pkg::buf_level_t level; // Shadow of the buffer fill level.
int                       idle_cnt; // Idle cycles since the last burst, saturating.

always_ff @(posedge clk) begin
    if (rst) begin
        level <= '0;
    end else if (rx_beat.valid && !pop) begin
        level <= level + 1'b1;
    end else if (!rx_beat.valid && pop) begin
        level <= level - 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        idle_cnt <= mii_loop_pkg::IFG_CYCLES; // The line counts as long idle after reset.
    end else if (phy_tx_en) begin
        idle_cnt <= 0;
    end else if (idle_cnt < mii_loop_pkg::IFG_CYCLES) begin
        idle_cnt <= idle_cnt + 1;
    end
end

pop_needs_head: assert property (@(posedge clk) disable iff (rst) pop |-> head.valid)
    else $error("pop was raised while the buffer was empty");

no_write_when_full: assert property (@(posedge clk) disable iff (rst)
    rx_beat.valid |-> level != mii_loop_pkg::buf_level_t'(mii_loop_pkg::BUF_DEPTH))
    else $error("a beat was written into a full buffer");

min_gap: assert property (@(posedge clk) disable iff (rst)
    $rose(phy_tx_en) |-> idle_cnt >= mii_loop_pkg::IFG_CYCLES)
    else $error("transmit burst started before the inter-frame gap ended");

endmodule

bind mii_loop_core mii_loop_core_chk chk_inst (
    .clk       (clk),
    .rst       (rst),
    .rx_beat   (rx_beat),
    .head      (head),
    .pop       (pop),
    .phy_tx_en (phy_tx_en)
);

`default_nettype wire

/* bench/mii_loop_core_tb.sv */
// Self-checking loopback test; frames go in raw at one nibble per clk and stay under the buffer depth.
`timescale 1ns/1ps
`default_nettype none

module mii_loop_core_tb;

localparam int NUM_FRAMES = 40;
localparam int WAIT_LIMIT = 5000; // Cycles any single wait may take.

logic                  clk = 1'b0;
logic                  rst;
logic [3:0]            btn;
logic [3:0]            sw;
logic [7:0]            led;
mii_loop_pkg::nibble_t phy_rxd;
logic                  phy_rx_dv;
logic                  phy_rx_er;
mii_loop_pkg::nibble_t phy_txd;
logic                  phy_tx_en;
logic                  phy_reset_n;
mii_loop_pkg::stats_t  stats;

mii_loop_pkg::byte_t   exp_bytes[$]; // Bytes expected on the transmit side, in order.
int                    exp_lens[$];
mii_loop_pkg::count_t  exp_rx_frames = '0;
mii_loop_pkg::count_t  exp_rx_bytes = '0;
mii_loop_pkg::count_t  exp_bad_frames = '0;
mii_loop_pkg::nibble_t frame_nibs[$];
int                    done_cycle[NUM_FRAMES]; // Cycle in which each frame's dv fell.
int                    sent_bytes = 0;
int                    tx_bytes = 0;
int                    frames_seen = 0;
int                    cycle = 0;
logic [15:0]           lfsr_state = 16'd61;

mii_loop_core UUT (
    .clk         (clk),
    .rst         (rst),
    .btn         (btn),
    .sw          (sw),
    .led         (led),
    .phy_rxd     (phy_rxd),
    .phy_rx_dv   (phy_rx_dv),
    .phy_rx_er   (phy_rx_er),
    .phy_txd     (phy_txd),
    .phy_tx_en   (phy_tx_en),
    .phy_reset_n (phy_reset_n),
    .stats       (stats)
);

always #50 clk = ~clk;

always @(posedge clk) begin
    cycle <= cycle + 1;
end

// Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1.
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

function automatic int unsigned random_bits(input int count);
    int unsigned value;
    int          k;
    value = 0;
    for (k = 0; k < count; k++) begin
        lfsr_state = lfsr_next(lfsr_state); // One step per bit taken.
        value = {value[30:0], lfsr_state[0]};
    end
    return value;
endfunction

// Pairs nibbles low first and drops an odd trailing nibble, as the MII receive side does.
function automatic void model_frame(input mii_loop_pkg::nibble_t nibs[$], input logic has_err);
    int nbytes;
    int i;
    nbytes = nibs.size() / 2;
    for (i = 0; i < nbytes; i++) begin
        exp_bytes.push_back({nibs[2 * i + 1], nibs[2 * i]});
    end
    exp_lens.push_back(nbytes);
    exp_rx_frames = exp_rx_frames + 1;
    exp_rx_bytes = exp_rx_bytes + mii_loop_pkg::count_t'(nbytes);
    if (has_err) begin
        exp_bad_frames = exp_bad_frames + 1; // Errored frames are still looped back.
    end
endfunction

task automatic stop_run(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1, "Simulation stopped at the first error.");
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        stop_run($sformatf("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
endtask

task automatic check_nibble(input string what, input mii_loop_pkg::nibble_t got,
                            input mii_loop_pkg::nibble_t exp);
    if (got !== exp) begin
        stop_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
endtask

task automatic check_byte(input string what, input mii_loop_pkg::byte_t got,
                          input mii_loop_pkg::byte_t exp);
    if (got !== exp) begin
        stop_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
endtask

task automatic check_count(input string what, input mii_loop_pkg::count_t got,
                           input mii_loop_pkg::count_t exp);
    if (got !== exp) begin
        stop_run($sformatf("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
    end
endtask

task automatic drive_rx(input mii_loop_pkg::nibble_t nib, input logic dv, input logic er);
    @(posedge clk);
    #1;
    phy_rxd   = nib;
    phy_rx_dv = dv;
    phy_rx_er = er;
endtask

initial begin : stimulus
    int                  f;
    int                  i;
    int                  len;
    int                  err_pos;
    int                  waited;
    logic                has_err;
    logic                odd;
    mii_loop_pkg::byte_t b;
    rst       = 1'b1;
    btn       = '0;
    sw        = '0;
    phy_rxd   = '0;
    phy_rx_dv = 1'b0;
    phy_rx_er = 1'b0;
    repeat (15) @(posedge clk);
    @(negedge clk);
    check_bit("phy_reset_n during reset", phy_reset_n, 1'b0);
    check_bit("phy_tx_en during reset", phy_tx_en, 1'b0);
    @(posedge clk);
    #1;
    rst = 1'b0; // Released after the sixteenth rising edge.
    @(negedge clk);
    check_bit("phy_reset_n after reset", phy_reset_n, 1'b1);
    check_bit("phy_tx_en after reset", phy_tx_en, 1'b0);
    check_count("rx_frames after reset", stats.rx_frames, '0);
    check_count("rx_bytes after reset", stats.rx_bytes, '0);
    check_count("rx_bad_frames after reset", stats.rx_bad_frames, '0);
    check_count("tx_frames after reset", stats.tx_frames, '0);
    for (i = 0; i < 8; i++) begin
        @(posedge clk);
        #1;
        btn = 4'(random_bits(4));
        sw  = 4'(random_bits(4));
        @(negedge clk);
        check_byte("led", led, {sw, btn}); // Switches sit above the buttons.
    end
    for (f = 0; f < NUM_FRAMES; f++) begin
        len = 8 + int'(random_bits(6) % 57);
        odd = (f == 0) || random_bits(1) == 1; // The first frame always has a spare nibble.
        frame_nibs.delete();
        for (i = 0; i < len; i++) begin
            b = mii_loop_pkg::byte_t'(random_bits(8));
            frame_nibs.push_back(b[3:0]);
            frame_nibs.push_back(b[7:4]);
        end
        if (odd) begin
            frame_nibs.push_back(mii_loop_pkg::nibble_t'(random_bits(4)));
        end
        has_err = (f == 1) || random_bits(3) == 0;
        err_pos = int'(random_bits(8) % frame_nibs.size());
        model_frame(frame_nibs, has_err);
        waited = 0;
        while (sent_bytes - tx_bytes + len >= mii_loop_pkg::BUF_DEPTH) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_run("Timed out waiting for room in the frame buffer.");
            end
        end
        for (i = 0; i < frame_nibs.size(); i++) begin
            drive_rx(frame_nibs[i], 1'b1, has_err && i == err_pos);
        end
        drive_rx('0, 1'b0, 1'b0);
        done_cycle[f] = cycle;
        sent_bytes += len;
        repeat (2 + int'(random_bits(4))) @(posedge clk);
    end
    waited = 0;
    while (frames_seen < NUM_FRAMES) begin
        @(negedge clk);
        waited++;
        if (waited > WAIT_LIMIT) begin
            stop_run("Timed out waiting for all frames to be transmitted.");
        end
    end
    repeat (4) @(negedge clk);
    check_count("rx_frames", stats.rx_frames, exp_rx_frames);
    check_count("rx_bytes", stats.rx_bytes, exp_rx_bytes);
    check_count("rx_bad_frames", stats.rx_bad_frames, exp_bad_frames);
    check_count("tx_frames", stats.tx_frames, mii_loop_pkg::count_t'(NUM_FRAMES));
    $display("Everything OK");
    $finish;
end

initial begin : compare_bursts
    int                  idle;
    int                  waited;
    int                  nbytes;
    int                  frame_idx;
    int                  burst_end;
    mii_loop_pkg::byte_t expected;
    waited = 0;
    while (rst !== 1'b0) begin
        @(negedge clk);
        waited++;
        if (waited > WAIT_LIMIT) begin
            stop_run("Reset was never released.");
        end
    end
    idle      = 0;
    burst_end = 0;
    for (frame_idx = 0; frame_idx < NUM_FRAMES; frame_idx++) begin
        waited = 0;
        while (phy_tx_en !== 1'b1) begin
            idle++;   // Each low sample is one idle cycle.
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_run("Timed out waiting for a transmit burst.");
            end
            @(negedge clk);
        end
        if (frame_idx > 0) begin
            if (done_cycle[frame_idx] < burst_end) begin
                // This frame was complete before the gap began, so the gap must be minimal.
                check_count("inter-frame gap", mii_loop_pkg::count_t'(idle),
                            mii_loop_pkg::count_t'(mii_loop_pkg::IFG_CYCLES));
            end else if (idle < mii_loop_pkg::IFG_CYCLES) begin
                stop_run($sformatf("Fail at %0t ns: inter-frame gap of %0d cycles is too short",
                                   $time, idle));
            end
        end
        nbytes = 0;
        while (phy_tx_en === 1'b1) begin
            if (exp_bytes.size() == 0) begin
                stop_run("The DUT transmitted a byte that was never received.");
            end
            expected = exp_bytes.pop_front();
            check_nibble("low nibble", phy_txd, expected[3:0]);
            @(negedge clk);
            if (phy_tx_en !== 1'b1) begin
                stop_run("A transmit burst ended after a low nibble.");
            end
            check_nibble("high nibble", phy_txd, expected[7:4]);
            nbytes++;
            tx_bytes++;
            @(negedge clk);
        end
        burst_end = cycle;
        idle      = 0;
        check_count("burst length in bytes", mii_loop_pkg::count_t'(nbytes),
                    mii_loop_pkg::count_t'(exp_lens.pop_front()));
        frames_seen++;
    end
end

endmodule

`default_nettype wire

/* mii_loop_core.f */
rtl/mii_loop_pkg.sv
rtl/mii_rx_framer.sv
rtl/frame_buffer.sv
rtl/frame_stats.sv
rtl/mii_tx_serializer.sv
rtl/mii_loop_core.sv
bench/mii_loop_core_chk.sv
bench/mii_loop_core_tb.sv

/* Makefile */
# Verilator build and run for the MII loopback core testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= mii_loop_core_tb
FILELIST  ?= mii_loop_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard rtl/*.sv bench/*.sv)
EXE     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator exits non-zero on $fatal or a failed assertion, so make fails too.
run: compile
	./$(EXE)

clean:
	rm -rf $(BUILD_DIR)
